//--- design/conv_pkg.sv
`default_nettype none

package conv_pkg;

  // pixel lanes and weight members per beat
  localparam int UNITS          = 4;
  localparam int MEMBERS        = 4;

  // datapath widths
  localparam int WORD_WIDTH     = 8;
  localparam int WORD_WIDTH_ACC = 24;
  localparam int WORD_WIDTH_OUT = 16;

  // config word fields, kernel length 1 to 255
  localparam int KBEATS_WIDTH   = 8;
  localparam int SHIFT_WIDTH    = 5;
  localparam int WEIGHT_WIDTH   = MEMBERS * WORD_WIDTH;
  localparam int CFG_PAD_WIDTH  = WEIGHT_WIDTH - KBEATS_WIDTH - SHIFT_WIDTH;

  // output bank member counter
  localparam int MEMBER_IDX_WIDTH = $clog2(MEMBERS);

  // signed 16 bit clamp range
  localparam int SAT_MAX = 2 ** (WORD_WIDTH_OUT - 1) - 1;
  localparam int SAT_MIN = -(2 ** (WORD_WIDTH_OUT - 1));

  typedef logic signed [WORD_WIDTH-1:0]     word_t;
  typedef logic signed [WORD_WIDTH_ACC-1:0] acc_t;
  typedef logic signed [WORD_WIDTH_OUT-1:0] out_word_t;

  // one pixel per unit
  typedef word_t [UNITS-1:0] pixel_beat_t;
  // one weight per member
  typedef word_t [MEMBERS-1:0] weight_vec_t;

  // first word of every weight packet
  typedef struct packed {
    logic [CFG_PAD_WIDTH-1:0] pad;
    logic [SHIFT_WIDTH-1:0]   out_shift;
    logic [KBEATS_WIDTH-1:0]  kernel_beats;
  } cfg_word_t;

  // weight stream word, config or weights depending on packet position
  typedef union packed {
    cfg_word_t   cfg;
    weight_vec_t weights;
  } weight_word_t;

  // pixel and weight beat taken together, 71 bits
  typedef struct packed {
    pixel_beat_t            pixels;
    weight_vec_t            weights;
    logic                   first;
    logic                   last;
    logic [SHIFT_WIDTH-1:0] out_shift;
  } join_beat_t;

  // member major accumulator array
  typedef acc_t [MEMBERS-1:0][UNITS-1:0] acc_bank_t;

  // finished kernel handed to the output bank
  typedef struct packed {
    acc_bank_t              sums;
    logic [SHIFT_WIDTH-1:0] out_shift;
  } result_bank_t;

  // one member's saturated results
  typedef out_word_t [UNITS-1:0] out_beat_t;

endpackage

`default_nettype wire

//--- design/conv_input_pipe.sv
`default_nettype none

module conv_input_pipe import conv_pkg::*; (
  input  wire logic         aclk,
  input  wire logic         arst_n,
  input  wire logic         s_pixels_valid,
  output logic              s_pixels_ready,
  input  wire pixel_beat_t  s_pixels_data,
  input  wire logic         s_weights_valid,
  output logic              s_weights_ready,
  input  wire weight_word_t s_weights_data,
  output logic              join_valid,
  input  wire logic         join_ready,
  output join_beat_t        join_beat
);

  // high while the next weight word is a config word
  logic                    expect_cfg;
  // latched config of the running kernel
  logic [KBEATS_WIDTH-1:0] kernel_beats_q;
  logic [SHIFT_WIDTH-1:0]  out_shift_q;
  // data beats already joined in this kernel
  logic [KBEATS_WIDTH-1:0] beat_cnt;
  logic                    cfg_take;
  logic                    join_fire;
  logic                    last_beat;

  // config word is taken alone, pixel stream held off
  assign cfg_take = expect_cfg & s_weights_valid;

  // data phase needs both streams at once
  assign join_valid = ~expect_cfg & s_pixels_valid & s_weights_valid;
  assign join_fire  = join_valid & join_ready;

  // readies follow the partner valid so both streams move together
  assign s_weights_ready = expect_cfg ? s_weights_valid : (s_pixels_valid & join_ready);
  assign s_pixels_ready  = ~expect_cfg & s_weights_valid & join_ready;

  // kernel ends on beat kernel_beats-1
  assign last_beat = (beat_cnt == kernel_beats_q - KBEATS_WIDTH'(1));

  // weights side of the union is read here
  always_comb begin
    join_beat.pixels    = s_pixels_data;
    join_beat.weights   = s_weights_data.weights;
    join_beat.first     = (beat_cnt == '0);
    join_beat.last      = last_beat;
    join_beat.out_shift = out_shift_q;
  end

  // two state FSM plus beat counter
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      expect_cfg     <= 1'b1;
      kernel_beats_q <= '0;
      out_shift_q    <= '0;
      beat_cnt       <= '0;
    end else if (cfg_take) begin
      // cfg side of the union
      expect_cfg     <= 1'b0;
      kernel_beats_q <= s_weights_data.cfg.kernel_beats;
      out_shift_q    <= s_weights_data.cfg.out_shift;
      beat_cnt       <= '0;
    end else if (join_fire) begin
      if (last_beat) begin
        // packet done, next word is config again
        expect_cfg <= 1'b1;
        beat_cnt   <= '0;
      end else begin
        beat_cnt <= beat_cnt + KBEATS_WIDTH'(1);
      end
    end
  end

  // zero length would never reach a last beat
  a_cfg_nonzero: assert property (@(posedge aclk) disable iff (!arst_n)
    cfg_take |-> (s_weights_data.cfg.kernel_beats != '0));

  // upstream must hold pixel data across a stall
  a_pixels_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    (s_pixels_valid && !s_pixels_ready) |=> $stable(s_pixels_data));

endmodule

`default_nettype wire

//--- design/conv_mac_engine.sv
`default_nettype none

module conv_mac_engine import conv_pkg::*; (
  input  wire logic       aclk,
  input  wire logic       arst_n,
  input  wire logic       join_valid,
  output logic            join_ready,
  input  wire join_beat_t join_beat,
  output logic            bank_valid,
  input  wire logic       bank_ready,
  output result_bank_t    bank
);

  // running sums per member and unit
  acc_bank_t acc;
  // sums including the current beat
  acc_bank_t next_sums;
  logic      join_fire;
  logic      kernel_end;
  // between a first beat and its last beat
  logic      in_kernel;

  // only a last beat needs the handoff register
  // a drain in the same cycle frees it in time
  assign join_ready = ~(join_beat.last & bank_valid & ~bank_ready);
  assign join_fire  = join_valid & join_ready;
  assign kernel_end = join_fire & join_beat.last;

  // MEMBERS x UNITS signed multipliers
  always_comb begin : mac_array
    logic signed [2*WORD_WIDTH-1:0] prod;
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        // weight m times pixel u, full 16 bit product
        prod = $signed(join_beat.weights[m]) * $signed(join_beat.pixels[u]);
        if (join_beat.first) begin
          // new kernel loads instead of adding
          next_sums[m][u] = WORD_WIDTH_ACC'(prod);
        end else begin
          next_sums[m][u] = $signed(acc[m][u]) + prod;
        end
      end
    end
  end

  // accumulate on every joined beat
  always_ff @(posedge aclk) begin
    if (join_fire) begin
      acc <= next_sums;
    end
  end

  // handoff register, loaded straight from next_sums
  // so the bank is valid one cycle after the last beat
  always_ff @(posedge aclk) begin
    if (kernel_end) begin
      bank.sums      <= next_sums;
      bank.out_shift <= join_beat.out_shift;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      bank_valid <= 1'b0;
      in_kernel  <= 1'b0;
    end else begin
      // a new result may replace one draining this cycle
      if (kernel_end) begin
        bank_valid <= 1'b1;
      end else if (bank_ready) begin
        bank_valid <= 1'b0;
      end
      if (join_fire) begin
        in_kernel <= ~join_beat.last;
      end
    end
  end

  // first only right after a last, and always there
  a_first_order: assert property (@(posedge aclk) disable iff (!arst_n)
    join_valid |-> (join_beat.first == !in_kernel));

endmodule

`default_nettype wire

//--- design/conv_dw_bank.sv
`default_nettype none

module conv_dw_bank import conv_pkg::*; (
  input  wire logic         aclk,
  input  wire logic         arst_n,
  input  wire logic         bank_valid,
  output logic              bank_ready,
  input  wire result_bank_t bank,
  output logic              m_valid,
  input  wire logic         m_ready,
  output out_beat_t         m_data,
  output logic              m_last
);

  // one stored result bank
  result_bank_t                bank_q;
  // member currently on the output
  logic [MEMBER_IDX_WIDTH-1:0] member_idx;
  logic                        bank_fire;
  logic                        out_fire;

  assign m_last   = (member_idx == MEMBER_IDX_WIDTH'(MEMBERS - 1));
  assign out_fire = m_valid & m_ready;

  // empty, or final member leaving this cycle
  assign bank_ready = ~m_valid | (m_ready & m_last);
  assign bank_fire  = bank_valid & bank_ready;

  // arithmetic shift then clamp to 16 bits
  always_comb begin : shift_sat
    acc_t shifted;
    for (int u = 0; u < UNITS; u++) begin
      shifted = $signed(bank_q.sums[member_idx][u]) >>> bank_q.out_shift;
      if (shifted > SAT_MAX) begin
        m_data[u] = WORD_WIDTH_OUT'(SAT_MAX);
      end else if (shifted < SAT_MIN) begin
        m_data[u] = WORD_WIDTH_OUT'(SAT_MIN);
      end else begin
        m_data[u] = shifted[WORD_WIDTH_OUT-1:0];
      end
    end
  end

  // bank payload
  always_ff @(posedge aclk) begin
    if (bank_fire) begin
      bank_q <= bank;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid    <= 1'b0;
      member_idx <= '0;
    end else begin
      // back to back banks keep m_valid high
      if (bank_fire) begin
        m_valid <= 1'b1;
      end else if (out_fire && m_last) begin
        m_valid <= 1'b0;
      end
      // member order 0 .. MEMBERS-1, then wrap
      if (out_fire) begin
        if (m_last) begin
          member_idx <= '0;
        end else begin
          member_idx <= member_idx + MEMBER_IDX_WIDTH'(1);
        end
      end
    end
  end

  // beat frozen while the sink stalls
  a_out_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)));

endmodule

`default_nettype wire

//--- design/conv_accel_top.sv
`default_nettype none

module conv_accel_top import conv_pkg::*; (
  input  wire logic         aclk,
  input  wire logic         arst_n,
  // pixel stream
  input  wire logic         s_pixels_valid,
  output wire logic         s_pixels_ready,
  input  wire pixel_beat_t  s_pixels_data,
  // weight stream, config word then kernel weights
  input  wire logic         s_weights_valid,
  output wire logic         s_weights_ready,
  input  wire weight_word_t s_weights_data,
  // results, one member per beat
  output wire logic         m_valid,
  input  wire logic         m_ready,
  output wire out_beat_t    m_data,
  output wire logic         m_last
);

  // joined beats into the MAC array
  wire logic         join_valid;
  wire logic         join_ready;
  wire join_beat_t   join_beat;

  // finished kernels into the output bank
  wire logic         bank_valid;
  wire logic         bank_ready;
  wire result_bank_t bank;

  // decode, config words filtered here
  conv_input_pipe u_input_pipe (
    .aclk            (aclk),
    .arst_n          (arst_n),
    .s_pixels_valid  (s_pixels_valid),
    .s_pixels_ready  (s_pixels_ready),
    .s_pixels_data   (s_pixels_data),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .s_weights_data  (s_weights_data),
    .join_valid      (join_valid),
    .join_ready      (join_ready),
    .join_beat       (join_beat)
  );

  // execute
  conv_mac_engine u_mac_engine (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .join_valid (join_valid),
    .join_ready (join_ready),
    .join_beat  (join_beat),
    .bank_valid (bank_valid),
    .bank_ready (bank_ready),
    .bank       (bank)
  );

  // result, shift and saturate per member
  conv_dw_bank u_dw_bank (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .bank_valid (bank_valid),
    .bank_ready (bank_ready),
    .bank       (bank),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_data     (m_data),
    .m_last     (m_last)
  );

endmodule

`default_nettype wire

//--- test/tb_conv_model.svh
`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

// data modes of a table row
localparam int MODE_RAND = 0;
localparam int MODE_MAX  = 1;
localparam int MODE_MIN  = 2;

// one table row, stall counts out of 16
typedef struct packed {
  logic [KBEATS_WIDTH-1:0] kernel_beats;
  logic [SHIFT_WIDTH-1:0]  out_shift;
  logic [1:0]              mode;
  logic [3:0]              stall;
} test_row_t;

test_row_t   test_table[$];
string       test_names[$];
logic [31:0] lfsr_state = 32'hf712;

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    bits = {bits[30:0], lfsr_state[0]};
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
  end
  return bits;
endfunction

// true when a valid or ready should be held off this cycle
function automatic logic gap(input int stall);
  return rand_bits(4) < stall;
endfunction

function automatic word_t make_word(input int mode);
  case (mode)
    MODE_MAX: return word_t'(127);
    MODE_MIN: return word_t'(-128);
    default:  return word_t'(rand_bits(WORD_WIDTH));
  endcase
endfunction

task automatic add_row(input string name, input int kb, input int sh,
                       input int mode, input int stall);
  test_row_t row;
  row.kernel_beats = KBEATS_WIDTH'(kb);
  row.out_shift    = SHIFT_WIDTH'(sh);
  row.mode         = 2'(mode);
  row.stall        = 4'(stall);
  test_table.push_back(row);
  test_names.push_back(name);
endtask

task automatic load_table();
  // single beats return the plain products
  add_row("single_beat_a", 1, 0, MODE_RAND, 0);
  add_row("single_beat_b", 1, 0, MODE_RAND, 0);
  add_row("single_beat_c", 1, 0, MODE_RAND, 3);
  // long random kernels, shifted
  add_row("rand_long_sh7", 200, 7, MODE_RAND, 0);
  add_row("rand_long_sh12", 255, 12, MODE_RAND, 2);
  // no shift, large sums clamp both ways
  add_row("rand_long_sh0", 255, 0, MODE_RAND, 0);
  add_row("all_max", 255, 0, MODE_MAX, 0);
  add_row("all_min", 255, 0, MODE_MIN, 0);
  // heavy gaps on inputs and m_ready
  add_row("stall_mid", 37, 3, MODE_RAND, 5);
  add_row("stall_short", 5, 1, MODE_RAND, 5);
  // back to back, each with its own shift
  add_row("b2b_sh31", 3, 31, MODE_RAND, 1);
  add_row("b2b_sh4", 9, 4, MODE_RAND, 0);
  add_row("b2b_sh20", 64, 20, MODE_RAND, 4);
endtask

// config word, data beats and expected member beats of one row
task automatic build_row(input int r);
  test_row_t    row;
  weight_word_t wword;
  pixel_beat_t  pbeat;
  out_beat_t    ebeat;
  longint       sums[MEMBERS][UNITS];
  longint       val;
  row   = test_table[r];
  wword = '0;
  wword.cfg.kernel_beats = row.kernel_beats;
  wword.cfg.out_shift    = row.out_shift;
  wgt_q.push_back(wword);
  wgt_row_q.push_back(r);
  for (int m = 0; m < MEMBERS; m++) begin
    for (int u = 0; u < UNITS; u++) begin
      sums[m][u] = 0;
    end
  end
  for (int b = 0; b < row.kernel_beats; b++) begin
    for (int u = 0; u < UNITS; u++) begin
      pbeat[u] = make_word(row.mode);
    end
    for (int m = 0; m < MEMBERS; m++) begin
      wword.weights[m] = make_word(row.mode);
    end
    pix_q.push_back(pbeat);
    pix_row_q.push_back(r);
    wgt_q.push_back(wword);
    wgt_row_q.push_back(r);
    // weight m times pixel u, summed over the kernel
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        sums[m][u] += longint'($signed(wword.weights[m])) * longint'($signed(pbeat[u]));
      end
    end
  end
  for (int m = 0; m < MEMBERS; m++) begin
    for (int u = 0; u < UNITS; u++) begin
      val = sums[m][u] >>> row.out_shift;
      // signed 16 bit range
      if (val > 32767) begin
        val = 32767;
      end else if (val < -32768) begin
        val = -32768;
      end
      ebeat[u] = val[15:0];
    end
    exp_q.push_back(ebeat);
    exp_last_q.push_back(m == MEMBERS - 1);
    exp_row_q.push_back(r);
  end
endtask

// generous per row budget plus reset slack
function automatic int timeout_cycles();
  int total;
  total = 100;
  foreach (test_table[i]) begin
    total += (int'(test_table[i].kernel_beats) + 1 + MEMBERS) * 8;
  end
  return total;
endfunction

`endif

//--- test/tb_conv_accel.sv
`default_nettype none

module tb_conv_accel import conv_pkg::*; ();

  logic         aclk;
  logic         arst_n;
  logic         s_pixels_valid;
  logic         s_pixels_ready;
  pixel_beat_t  s_pixels_data;
  logic         s_weights_valid;
  logic         s_weights_ready;
  weight_word_t s_weights_data;
  logic         m_valid;
  logic         m_ready;
  out_beat_t    m_data;
  logic         m_last;

  // stimulus and expected beats tagged with their table row
  pixel_beat_t  pix_q[$];
  int           pix_row_q[$];
  weight_word_t wgt_q[$];
  int           wgt_row_q[$];
  out_beat_t    exp_q[$];
  logic         exp_last_q[$];
  int           exp_row_q[$];

  logic         run_active;
  int           cycle_cnt;
  int           timeout_limit;
  // handshake and flag outputs right after reset
  logic [3:0]   reset_flags;

  `include "tb_conv_model.svh"

  conv_accel_top u_dut (
    .aclk            (aclk),
    .arst_n          (arst_n),
    .s_pixels_valid  (s_pixels_valid),
    .s_pixels_ready  (s_pixels_ready),
    .s_pixels_data   (s_pixels_data),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .s_weights_data  (s_weights_data),
    .m_valid         (m_valid),
    .m_ready         (m_ready),
    .m_data          (m_data),
    .m_last          (m_last)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout: results still missing after %0d cycles", cycle_cnt);
      $display("Verification failed");
      $fatal(1, "run stopped at the cycle limit");
    end
  end

  // input drivers, m_ready and the output checker
  always @(posedge aclk) begin : drive_check
    logic      pix_fire;
    logic      wgt_fire;
    out_beat_t exp_beat;
    logic      exp_last;
    int        exp_row;
    if (run_active) begin
      pix_fire = s_pixels_valid && s_pixels_ready;
      wgt_fire = s_weights_valid && s_weights_ready;
      if (m_valid && m_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("an output beat arrived with no result pending");
          $display("Verification failed");
          $fatal(1, "extra output beat");
        end
        exp_beat = exp_q.pop_front();
        exp_last = exp_last_q.pop_front();
        exp_row  = exp_row_q.pop_front();
        assert (m_data == exp_beat) else begin
          $display("error: %s expected %h actual %h", test_names[exp_row], exp_beat, m_data);
          $display("Verification failed");
          $fatal(1, "m_data mismatch");
        end
        assert (m_last == exp_last) else begin
          $display("error: %s expected m_last %b actual %b", test_names[exp_row],
                   exp_last, m_last);
          $display("Verification failed");
          $fatal(1, "m_last mismatch");
        end
      end
      // pixel stream holds valid until taken
      if (pix_fire) begin
        void'(pix_q.pop_front());
        void'(pix_row_q.pop_front());
      end
      if (!s_pixels_valid || pix_fire) begin
        if (pix_q.size() != 0 && !gap(test_table[pix_row_q[0]].stall)) begin
          s_pixels_valid <= 1'b1;
          s_pixels_data  <= pix_q[0];
        end else begin
          s_pixels_valid <= 1'b0;
        end
      end
      // weight stream with a config word leading every packet
      if (wgt_fire) begin
        void'(wgt_q.pop_front());
        void'(wgt_row_q.pop_front());
      end
      if (!s_weights_valid || wgt_fire) begin
        if (wgt_q.size() != 0 && !gap(test_table[wgt_row_q[0]].stall)) begin
          s_weights_valid <= 1'b1;
          s_weights_data  <= wgt_q[0];
        end else begin
          s_weights_valid <= 1'b0;
        end
      end
      // back-pressure follows the row now draining
      if (exp_q.size() == 0) begin
        m_ready <= 1'b1;
      end else begin
        m_ready <= !gap(test_table[exp_row_q[0]].stall);
      end
    end
  end

  initial begin
    arst_n          = 1'b0;
    s_pixels_valid  = 1'b0;
    s_pixels_data   = '0;
    s_weights_valid = 1'b0;
    s_weights_data  = '0;
    m_ready         = 1'b0;
    run_active      = 1'b0;
    cycle_cnt       = 0;
    load_table();
    timeout_limit = timeout_cycles();
    // every row queued ahead so kernels run back to back
    for (int r = 0; r < test_table.size(); r++) begin
      build_row(r);
    end
    repeat (4) @(posedge aclk);
    arst_n <= 1'b1;
    @(negedge aclk);
    reset_flags = {m_valid, m_last, s_pixels_ready, s_weights_ready};
    assert (reset_flags === 4'b0000) else begin
      $display("error: after_reset expected m_valid m_last readies %b actual %b",
               4'b0000, reset_flags);
      $display("Verification failed");
      $fatal(1, "outputs high after reset");
    end
    run_active = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge aclk);
    end
    // idle cycles to catch a duplicated beat
    repeat (10) @(negedge aclk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+test
design/conv_pkg.sv
design/conv_input_pipe.sv
design/conv_mac_engine.sv
design/conv_dw_bank.sv
design/conv_accel_top.sv
test/tb_conv_accel.sv

//--- Bender.yml
package:
  name: conv_accel

sources:
  # package first, then the pipeline stages and the top level
  - design/conv_pkg.sv
  - design/conv_input_pipe.sv
  - design/conv_mac_engine.sv
  - design/conv_dw_bank.sv
  - design/conv_accel_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_conv_accel.sv
